// File: rtl/beamform_defines.svh
/* beamformer widths and counts */

`ifndef BEAMFORM_DEFINES_SVH
`define BEAMFORM_DEFINES_SVH

// one real or imaginary sample
`define BF_SAMPLE_WIDTH 16

// one weight component, read as a signed Q1.7 fraction
`define BF_WEIGHT_WIDTH 8

// samples per beat half and antenna channels summed per beat
`define BF_LANES 8
`define BF_CHANNELS 4

// fraction bits of a weight, removed by one arithmetic shift after the sum
`define BF_FRAC_BITS 7

// a 16x8 product plus one bit for the add inside the complex product
`define BF_PRODUCT_WIDTH (`BF_SAMPLE_WIDTH + `BF_WEIGHT_WIDTH + 1)

// two more bits cover the sum of four channels
`define BF_SUM_WIDTH (`BF_PRODUCT_WIDTH + 2)

// one beat half carries all lanes side by side
`define BF_WORD_WIDTH (`BF_SAMPLE_WIDTH * `BF_LANES)

`endif

// File: rtl/beamform_pkg.sv
/* beamformer shared types */

package beamform_pkg;

    `include "beamform_defines.svh"

    // one signed sample of a real or imaginary stream
    typedef logic signed [`BF_SAMPLE_WIDTH-1:0] sample_t;

    // one signed weight component in Q1.7
    typedef logic signed [`BF_WEIGHT_WIDTH-1:0] weight_t;

    // one component of a complex product, full width and unscaled
    typedef logic signed [`BF_PRODUCT_WIDTH-1:0] product_t;

    // one component of the four-channel sum before the shift
    typedef logic signed [`BF_SUM_WIDTH-1:0] sum_t;

    // one beat half, lane 0 sits in the low sixteen bits
    typedef sample_t [`BF_LANES-1:0] word_t;

    // products of one channel, one per lane with lane 0 in the low bits
    typedef product_t [`BF_LANES-1:0] product_word_t;

endpackage

// File: rtl/beam_weight_bank.sv
/* channel weight register bank */

`timescale 1ns/100ps

`include "beamform_defines.svh"

module beam_weight_bank (
    input  logic                  clock,
    input  logic                  resetn,

    // load strobe and the four complex weights it captures
    input  logic                  weight_load,
    input  beamform_pkg::weight_t weight_re [`BF_CHANNELS],
    input  beamform_pkg::weight_t weight_im [`BF_CHANNELS],

    // held weights, one pair per channel multiplier
    output beamform_pkg::weight_t coef_re [`BF_CHANNELS],
    output beamform_pkg::weight_t coef_im [`BF_CHANNELS]
);

    // the weights only change on a load, so beats that stream through
    // between two loads all see the same set
    // new values show up on coef one cycle after the strobe
    always_ff @(posedge clock) begin
        if (!resetn) begin
            // a zero weight set mutes every channel until the first load
            for (int ch = 0; ch < `BF_CHANNELS; ch++) begin
                coef_re[ch] <= '0;
                coef_im[ch] <= '0;
            end
        end else if (weight_load) begin
            // all four pairs reload together, there is no per-channel write
            for (int ch = 0; ch < `BF_CHANNELS; ch++) begin
                coef_re[ch] <= weight_re[ch];
                coef_im[ch] <= weight_im[ch];
            end
        end
    end

    // a load in the same cycle as a beat affects that beat too, since the
    // products are formed one edge after the beat is captured

endmodule

// File: rtl/complex_weight_mult.sv
/* per-channel complex weighting */

`timescale 1ns/100ps

`include "beamform_defines.svh"

module complex_weight_mult (
    input  logic                        clock,
    input  logic                        resetn,

    // one channel's beat, qualified by the shared valid strobe
    input  logic                        in_valid,
    input  beamform_pkg::word_t         in_re,
    input  beamform_pkg::word_t         in_im,

    // this channel's held complex weight
    input  beamform_pkg::weight_t       coef_re,
    input  beamform_pkg::weight_t       coef_im,

    // full width complex products, one per lane
    output beamform_pkg::product_word_t prod_re,
    output beamform_pkg::product_word_t prod_im
);

    // captured beat, split into signed lanes so the multiplies below
    // see signed operands without any casting
    beamform_pkg::sample_t sample_re [`BF_LANES];
    beamform_pkg::sample_t sample_im [`BF_LANES];

    // first stage, the beat is taken on the edge where in_valid is high
    // and held until the next valid beat
    always_ff @(posedge clock) begin
        if (!resetn) begin
            for (int lane = 0; lane < `BF_LANES; lane++) begin
                sample_re[lane] <= '0;
                sample_im[lane] <= '0;
            end
        end else if (in_valid) begin
            for (int lane = 0; lane < `BF_LANES; lane++) begin
                sample_re[lane] <= in_re[lane];
                sample_im[lane] <= in_im[lane];
            end
        end
    end

    // second stage, one edge after the capture
    // (a + jb)(c + jd) = (ac - bd) + j(ad + bc) for every lane
    // each partial product is 24 bits, the add or subtract needs the 25th
    // nothing is scaled here, the fraction bits are dropped after the sum
    always_ff @(posedge clock) begin : product_stage
        beamform_pkg::product_t mult_rr;
        beamform_pkg::product_t mult_ii;
        beamform_pkg::product_t mult_ri;
        beamform_pkg::product_t mult_ir;

        for (int lane = 0; lane < `BF_LANES; lane++) begin
            // operands are sign extended to the product width first
            mult_rr = sample_re[lane] * coef_re;
            mult_ii = sample_im[lane] * coef_im;
            mult_ri = sample_re[lane] * coef_im;
            mult_ir = sample_im[lane] * coef_re;

            // real part
            prod_re[lane] <= mult_rr - mult_ii;

            // imaginary part
            prod_im[lane] <= mult_ri + mult_ir;
        end
    end

    // the product stage runs every cycle, so a beat that arrives back to
    // back with the previous one still gets its own products one edge later
    // the valid qualification of the result lives in the summer, which
    // delays in_valid by the same number of edges

endmodule

// File: rtl/beam_sum_output.sv
/* channel sum, scale and saturate */

`timescale 1ns/100ps

`include "beamform_defines.svh"

module beam_sum_output (
    input  logic                        clock,
    input  logic                        resetn,

    // input side strobes, taken straight from the top level ports
    input  logic                        in_valid,
    input  logic                        in_last,

    // registered products of all four channels
    input  beamform_pkg::product_word_t prod_re [`BF_CHANNELS],
    input  beamform_pkg::product_word_t prod_im [`BF_CHANNELS],

    // summed beam, three edges after the beat entered
    output beamform_pkg::word_t         out_re,
    output beamform_pkg::word_t         out_im,
    output logic                        out_valid,
    output logic                        out_last
);

    // clamp limits of a signed sample, held at the sum width for compares
    localparam beamform_pkg::sum_t sat_max = (2 ** (`BF_SAMPLE_WIDTH - 1)) - 1;
    localparam beamform_pkg::sum_t sat_min = -(2 ** (`BF_SAMPLE_WIDTH - 1));

    // the first two delay stages, out_valid and out_last are the third
    logic [1:0] valid_pipe;
    logic [1:0] last_pipe;

    // four-channel sums per lane before scaling
    beamform_pkg::sum_t sum_re [`BF_LANES];
    beamform_pkg::sum_t sum_im [`BF_LANES];

    // drops the Q1.7 fraction bits and clamps to the sample range
    function automatic beamform_pkg::sample_t scale_saturate(beamform_pkg::sum_t value);
        beamform_pkg::sum_t shifted;

        // arithmetic shift, so negative sums round toward minus infinity
        shifted = value >>> `BF_FRAC_BITS;
        if (shifted > sat_max) begin
            return beamform_pkg::sample_t'(sat_max);
        end else if (shifted < sat_min) begin
            return beamform_pkg::sample_t'(sat_min);
        end
        return shifted[`BF_SAMPLE_WIDTH-1:0];
    endfunction

    // each product is sign extended into the sum width before the add
    always_comb begin
        for (int lane = 0; lane < `BF_LANES; lane++) begin
            sum_re[lane] = '0;
            sum_im[lane] = '0;
            for (int ch = 0; ch < `BF_CHANNELS; ch++) begin
                sum_re[lane] = sum_re[lane] + beamform_pkg::product_t'(prod_re[ch][lane]);
                sum_im[lane] = sum_im[lane] + beamform_pkg::product_t'(prod_im[ch][lane]);
            end
        end
    end

    // valid and last walk alongside the data through capture, products
    // and this output register
    always_ff @(posedge clock) begin
        if (!resetn) begin
            valid_pipe <= '0;
            last_pipe  <= '0;
            out_valid  <= 1'b0;
            out_last   <= 1'b0;
        end else begin
            valid_pipe <= {valid_pipe[0], in_valid};
            last_pipe  <= {last_pipe[0], in_last};
            out_valid  <= valid_pipe[1];
            // a last flag without its beat is not passed on
            out_last   <= last_pipe[1] & valid_pipe[1];
        end
    end

    // idle cycles leave the products of the previous beat in place, so the
    // data is forced to zero whenever the aligned valid is low
    always_ff @(posedge clock) begin
        if (!resetn) begin
            out_re <= '0;
            out_im <= '0;
        end else if (valid_pipe[1]) begin
            for (int lane = 0; lane < `BF_LANES; lane++) begin
                out_re[lane] <= scale_saturate(sum_re[lane]);
                out_im[lane] <= scale_saturate(sum_im[lane]);
            end
        end else begin
            out_re <= '0;
            out_im <= '0;
        end
    end

endmodule

// File: rtl/beamform_sum_top.sv
/* four-channel receive beamformer */

`timescale 1ns/100ps

`include "beamform_defines.svh"

module beamform_sum_top (
    input  logic                  clock,
    input  logic                  resetn,

    // weight load, one complex weight per channel
    input  logic                  weight_load,
    input  beamform_pkg::weight_t weight_re [`BF_CHANNELS],
    input  beamform_pkg::weight_t weight_im [`BF_CHANNELS],

    // input beat, all four channels share one valid and one last
    input  logic                  in_valid,
    input  beamform_pkg::word_t   in_re [`BF_CHANNELS],
    input  beamform_pkg::word_t   in_im [`BF_CHANNELS],
    input  logic                  in_last,

    // summed beam output
    output beamform_pkg::word_t   out_re,
    output beamform_pkg::word_t   out_im,
    output logic                  out_valid,
    output logic                  out_last
);

    // held weights from the bank to the multipliers
    beamform_pkg::weight_t coef_re [`BF_CHANNELS];
    beamform_pkg::weight_t coef_im [`BF_CHANNELS];

    // per-channel products into the summer
    beamform_pkg::product_word_t prod_re [`BF_CHANNELS];
    beamform_pkg::product_word_t prod_im [`BF_CHANNELS];

    // weights are decoupled from the data path and only move on a load
    beam_weight_bank u_weight_bank (
        .clock       (clock),
        .resetn      (resetn),
        .weight_load (weight_load),
        .weight_re   (weight_re),
        .weight_im   (weight_im),
        .coef_re     (coef_re),
        .coef_im     (coef_im)
    );

    // one multiplier per antenna channel, each with its own weight pair
    // all of them capture on the shared in_valid, so their products line up
    for (genvar ch = 0; ch < `BF_CHANNELS; ch++) begin : g_channel
        complex_weight_mult u_mult (
            .clock    (clock),
            .resetn   (resetn),
            .in_valid (in_valid),
            .in_re    (in_re[ch]),
            .in_im    (in_im[ch]),
            .coef_re  (coef_re[ch]),
            .coef_im  (coef_im[ch]),
            .prod_re  (prod_re[ch]),
            .prod_im  (prod_im[ch])
        );
    end

    // the summer delays valid and last itself, two edges in the
    // multipliers plus its own output register give the three cycle latency
    beam_sum_output u_sum_output (
        .clock     (clock),
        .resetn    (resetn),
        .in_valid  (in_valid),
        .in_last   (in_last),
        .prod_re   (prod_re),
        .prod_im   (prod_im),
        .out_re    (out_re),
        .out_im    (out_im),
        .out_valid (out_valid),
        .out_last  (out_last)
    );

    // there is no back-pressure anywhere, a beat may enter every cycle and
    // up to three beats are in flight between the ports

endmodule

// File: verification/tb_beamform_sum.sv
/* beamformer testbench */

`timescale 1ns/100ps

`include "beamform_defines.svh"

module tb_beamform_sum;

    // DUT inputs
    logic                  clock;
    logic                  resetn;
    logic                  weight_load;
    beamform_pkg::weight_t weight_re [`BF_CHANNELS];
    beamform_pkg::weight_t weight_im [`BF_CHANNELS];
    logic                  in_valid;
    beamform_pkg::word_t   in_re [`BF_CHANNELS];
    beamform_pkg::word_t   in_im [`BF_CHANNELS];
    logic                  in_last;

    // DUT outputs
    beamform_pkg::word_t   out_re;
    beamform_pkg::word_t   out_im;
    logic                  out_valid;
    logic                  out_last;

    // values that the next drive_cycle call puts on the ports
    beamform_pkg::word_t   stage_re [`BF_CHANNELS];
    beamform_pkg::word_t   stage_im [`BF_CHANNELS];
    beamform_pkg::weight_t stage_w_re [`BF_CHANNELS];
    beamform_pkg::weight_t stage_w_im [`BF_CHANNELS];

    // weight set that the model believes the bank holds
    beamform_pkg::weight_t model_w_re [`BF_CHANNELS];
    beamform_pkg::weight_t model_w_im [`BF_CHANNELS];

    // expected beats in input order, with the cycle in which each one entered
    beamform_pkg::word_t   exp_re_q [$];
    beamform_pkg::word_t   exp_im_q [$];
    logic                  exp_last_q [$];
    int                    exp_cycle_q [$];

    logic [31:0] lcg_state;
    int          cycle_idx;
    logic        checks_on;
    int          check_count;
    int          error_count;
    int          sent_count;
    int          recv_count;

    beamform_sum_top u_dut (
        .clock       (clock),
        .resetn      (resetn),
        .weight_load (weight_load),
        .weight_re   (weight_re),
        .weight_im   (weight_im),
        .in_valid    (in_valid),
        .in_re       (in_re),
        .in_im       (in_im),
        .in_last     (in_last),
        .out_re      (out_re),
        .out_im      (out_im),
        .out_valid   (out_valid),
        .out_last    (out_last)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // the low bits of a plain 32-bit LCG cycle fast, so callers take the upper bits
    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic beamform_pkg::sample_t clamp_sample(input int value);
        if (value > 32767) begin
            return 16'sd32767;
        end else if (value < -32768) begin
            return 16'sh8000;
        end
        return value[15:0];
    endfunction

    // the expected beam for one beat takes full complex products per channel, sums
    // them over the channels, shifts by the weight fraction bits and then clamps
    function automatic void beam_reference(
        input  beamform_pkg::word_t   re_in [`BF_CHANNELS],
        input  beamform_pkg::word_t   im_in [`BF_CHANNELS],
        input  beamform_pkg::weight_t w_re [`BF_CHANNELS],
        input  beamform_pkg::weight_t w_im [`BF_CHANNELS],
        output beamform_pkg::word_t   re_out,
        output beamform_pkg::word_t   im_out
    );
        int acc_re;
        int acc_im;
        int sr;
        int si;
        int wr;
        int wi;

        for (int lane = 0; lane < `BF_LANES; lane++) begin
            acc_re = 0;
            acc_im = 0;
            for (int ch = 0; ch < `BF_CHANNELS; ch++) begin
                sr = int'(re_in[ch][lane]);
                si = int'(im_in[ch][lane]);
                wr = int'(w_re[ch]);
                wi = int'(w_im[ch]);
                acc_re = acc_re + sr * wr - si * wi;
                acc_im = acc_im + sr * wi + si * wr;
            end
            re_out[lane] = clamp_sample(acc_re >>> `BF_FRAC_BITS);
            im_out[lane] = clamp_sample(acc_im >>> `BF_FRAC_BITS);
        end
    endfunction

    task automatic check_value(input string what, input logic signed [63:0] got,
                               input logic signed [63:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("mismatch at %0t ns: %s, got %0d expected %0d", $time, what, got, expected);
        end
    endtask

    // every DUT input is driven from the staged values on one rising edge
    task automatic drive_cycle(input logic valid, input logic last, input logic load);
        @(posedge clock);
        weight_load <= load;
        in_valid    <= valid;
        in_last     <= last;
        for (int ch = 0; ch < `BF_CHANNELS; ch++) begin
            in_re[ch]     <= stage_re[ch];
            in_im[ch]     <= stage_im[ch];
            weight_re[ch] <= stage_w_re[ch];
            weight_im[ch] <= stage_w_im[ch];
        end
    endtask

    task automatic fill_random_beat();
        logic [31:0] rnd;

        for (int ch = 0; ch < `BF_CHANNELS; ch++) begin
            for (int lane = 0; lane < `BF_LANES; lane++) begin
                rnd = next_random();
                stage_re[ch][lane] = rnd[31:16];
                rnd = next_random();
                stage_im[ch][lane] = rnd[31:16];
            end
        end
    endtask

    task automatic fill_const_beat(input int re_val, input int im_val);
        for (int ch = 0; ch < `BF_CHANNELS; ch++) begin
            for (int lane = 0; lane < `BF_LANES; lane++) begin
                stage_re[ch][lane] = re_val[15:0];
                stage_im[ch][lane] = im_val[15:0];
            end
        end
    endtask

    task automatic fill_random_weights();
        logic [31:0] rnd;

        for (int ch = 0; ch < `BF_CHANNELS; ch++) begin
            rnd = next_random();
            stage_w_re[ch] = rnd[31:24];
            stage_w_im[ch] = rnd[23:16];
        end
    endtask

    task automatic set_all_weights(input int w_re, input int w_im);
        for (int ch = 0; ch < `BF_CHANNELS; ch++) begin
            stage_w_re[ch] = w_re[7:0];
            stage_w_im[ch] = w_im[7:0];
        end
    endtask

    // loads one weight pair on every channel and then sends a full-scale beat
    task automatic send_saturation_case(input int w_re, input int w_im, input int sample);
        set_all_weights(w_re, w_im);
        drive_cycle(1'b0, 1'b0, 1'b1);
        fill_const_beat(sample, sample);
        drive_cycle(1'b1, 1'b0, 1'b0);
    endtask

    // inputs and outputs have both settled by the falling edge, so both are sampled there
    // beats are recorded with the weights of a load in the same cycle, since
    // the products are formed one edge after the bank has taken the new set
    always @(negedge clock) begin : track_and_compare
        beamform_pkg::word_t want_re;
        beamform_pkg::word_t want_im;
        logic                want_last;
        int                  entered;

        cycle_idx++;
        if (!resetn) begin
            for (int ch = 0; ch < `BF_CHANNELS; ch++) begin
                model_w_re[ch] = '0;
                model_w_im[ch] = '0;
            end
        end else begin
            if (weight_load) begin
                for (int ch = 0; ch < `BF_CHANNELS; ch++) begin
                    model_w_re[ch] = weight_re[ch];
                    model_w_im[ch] = weight_im[ch];
                end
            end
            if (in_valid) begin
                beam_reference(in_re, in_im, model_w_re, model_w_im, want_re, want_im);
                exp_re_q.push_back(want_re);
                exp_im_q.push_back(want_im);
                exp_last_q.push_back(in_last);
                exp_cycle_q.push_back(cycle_idx);
                sent_count++;
            end
        end

        if (checks_on) begin
            if (out_valid === 1'b1) begin
                if (exp_re_q.size() == 0) begin
                    error_count++;
                    $display("out_valid was raised at %0t ns with no beat waiting for it", $time);
                end else begin
                    want_re   = exp_re_q.pop_front();
                    want_im   = exp_im_q.pop_front();
                    want_last = exp_last_q.pop_front();
                    entered   = exp_cycle_q.pop_front();
                    for (int lane = 0; lane < `BF_LANES; lane++) begin
                        check_value($sformatf("beat %0d out_re lane %0d", recv_count, lane),
                                    out_re[lane], want_re[lane]);
                        check_value($sformatf("beat %0d out_im lane %0d", recv_count, lane),
                                    out_im[lane], want_im[lane]);
                    end
                    check_value($sformatf("beat %0d out_last", recv_count), out_last, want_last);
                    check_value($sformatf("beat %0d latency in cycles", recv_count),
                                cycle_idx - entered, 3);
                    recv_count++;
                end
            end else begin
                // idle cycles, including reset, show low strobes and zero data
                check_value("out_valid while idle", out_valid, 0);
                check_value("out_last while idle", out_last, 0);
                for (int lane = 0; lane < `BF_LANES; lane++) begin
                    check_value($sformatf("idle out_re lane %0d", lane), out_re[lane], 0);
                    check_value($sformatf("idle out_im lane %0d", lane), out_im[lane], 0);
                end
            end
        end
    end

    initial begin : stimulus
        logic [31:0] rnd;
        int          gap;

        lcg_state   = 32'hc7d7_0607;
        cycle_idx   = 0;
        checks_on   = 1'b0;
        check_count = 0;
        error_count = 0;
        sent_count  = 0;
        recv_count  = 0;
        resetn      = 1'b0;
        weight_load = 1'b0;
        in_valid    = 1'b0;
        in_last     = 1'b0;
        for (int ch = 0; ch < `BF_CHANNELS; ch++) begin
            weight_re[ch]  = '0;
            weight_im[ch]  = '0;
            in_re[ch]      = '0;
            in_im[ch]      = '0;
            stage_re[ch]   = '0;
            stage_im[ch]   = '0;
            stage_w_re[ch] = '0;
            stage_w_im[ch] = '0;
            model_w_re[ch] = '0;
            model_w_im[ch] = '0;
        end

        // outputs are checked from the first of the two reset edges on
        @(posedge clock);
        checks_on = 1'b1;
        @(posedge clock);
        resetn <= 1'b1;

        // beats before any load meet an all-zero weight set
        fill_random_beat();
        drive_cycle(1'b1, 1'b0, 1'b0);
        fill_random_beat();
        drive_cycle(1'b1, 1'b0, 1'b0);
        drive_cycle(1'b0, 1'b0, 1'b0);

        // channel 0 alone with a weight just under one
        set_all_weights(0, 0);
        stage_w_re[0] = 8'sd127;
        drive_cycle(1'b0, 1'b0, 1'b1);
        fill_const_beat(-1, 300);
        drive_cycle(1'b1, 1'b0, 1'b0);
        fill_const_beat(-32768, -129);
        drive_cycle(1'b1, 1'b0, 1'b0);
        for (int i = 0; i < 6; i++) begin
            fill_random_beat();
            drive_cycle(1'b1, 1'b0, 1'b0);
        end
        drive_cycle(1'b0, 1'b0, 1'b0);

        // random complex weights on all four channels
        fill_random_weights();
        drive_cycle(1'b0, 1'b0, 1'b1);
        for (int i = 0; i < 12; i++) begin
            fill_random_beat();
            drive_cycle(1'b1, 1'b0, 1'b0);
        end

        // sums far beyond the sample range in both directions
        send_saturation_case(-128, 127, -32768);
        send_saturation_case(127, -128, 32767);
        send_saturation_case(-128, 127, 32767);
        send_saturation_case(127, 127, 32767);
        send_saturation_case(127, 127, -32768);

        // back to back stream with a reload in the middle and last on every fifth beat
        fill_random_weights();
        drive_cycle(1'b0, 1'b0, 1'b1);
        for (int i = 0; i < 20; i++) begin
            if (i == 10) begin
                fill_random_weights();
            end
            fill_random_beat();
            drive_cycle(1'b1, (i % 5) == 4, i == 10);
        end

        // random idle gaps with junk on the data ports
        for (int i = 0; i < 10; i++) begin
            fill_random_beat();
            drive_cycle(1'b1, i == 9, 1'b0);
            rnd = next_random();
            gap = 1 + (rnd[31:28] % 3);
            for (int g = 0; g < gap; g++) begin
                fill_random_beat();
                drive_cycle(1'b0, 1'b0, 1'b0);
            end
        end
        drive_cycle(1'b0, 1'b0, 1'b0);

        // wait for the pipeline to drain, then watch a few idle cycles
        // the queue is looked at on the rising edge, after the falling edge compare
        for (int i = 0; i < 20 && exp_re_q.size() != 0; i++) begin
            @(posedge clock);
        end
        if (exp_re_q.size() != 0) begin
            error_count++;
            $display("timed out waiting for %0d beats to come out", exp_re_q.size());
        end
        for (int i = 0; i < 5; i++) begin
            @(posedge clock);
        end

        $display("checks %0d, errors %0d, beats sent %0d, beats received %0d",
                 check_count, error_count, sent_count, recv_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+rtl
rtl/beamform_pkg.sv
rtl/beam_weight_bank.sv
rtl/complex_weight_mult.sv
rtl/beam_sum_output.sv
rtl/beamform_sum_top.sv
verification/tb_beamform_sum.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the beamformer testbench with Verilator and runs it
# the exit status is 0 only when the log holds the pass message

cd "$(dirname "$0")" || exit 1

top=tb_beamform_sum
build_dir=obj_dir
log_file=sim.log

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator was not found on the PATH"
    exit 1
fi

rm -rf "$build_dir" "$log_file"

if ! verilator --binary --timing -Wno-fatal \
        --top-module "$top" -Mdir "$build_dir" -f verilog.f; then
    echo "verilator build failed"
    exit 1
fi

if ! "./$build_dir/V$top" > "$log_file" 2>&1; then
    cat "$log_file"
    echo "simulation exited with an error"
    exit 1
fi

cat "$log_file"

if grep -q "ALL TESTS PASSED" "$log_file"; then
    exit 0
fi

echo "pass message not found in $log_file"
exit 1
